// File: source/thumb_decode_params.svh
`ifndef THUMB_DECODE_PARAMS_SVH
`define THUMB_DECODE_PARAMS_SVH

// width of a built immediate, matching the core datapath
`define THUMB_WORD 32

// width of one Thumb instruction halfword
`define THUMB_HALF 16

// a literal load sees the PC as its own address plus 4
`define PC_READ_OFFSET 4

// the BL offset is formed while the second halfword is current, so the
// PC already sits 2 bytes past the start of the 32-bit instruction
`define BL_HALF_OFFSET 2

`endif

// File: source/thumb_pkg.sv
package thumb_pkg;

    // major opcode classes, each value is a representative of bits 15:10
    typedef enum logic [5:0] {
        SHIFT_IMM       = 6'b000000,
        DATA_PROCESSING = 6'b010000,
        SPECIAL         = 6'b010001,
        LOAD_LITERAL    = 6'b010010,
        LOAD_STORE_IMM  = 6'b011000,
        LOAD_STORE_BYTE = 6'b011100,
        LOAD_STORE_HW   = 6'b100000,
        LOAD_STORE_SP_R = 6'b100100,
        GEN_PC_REL      = 6'b101000,
        GEN_SP_REL      = 6'b101010,
        MIS_16_BIT      = 6'b101100,
        COND_BRANCH     = 6'b110100,
        UNCOND_BRANCH   = 6'b111000,
        BL_PREFIX       = 6'b111100,
        BL_SUFFIX       = 6'b111110
    } opcode_e;

    // shift, add, subtract, move and compare forms, from bits 13:9
    typedef enum logic [4:0] {
        LSL  = 5'b00000,
        LSR  = 5'b00100,
        ASR  = 5'b01000,
        ADD3 = 5'b01110,
        SUB3 = 5'b01111,
        MOV8 = 5'b10000,
        CMP8 = 5'b10100,
        ADD8 = 5'b11000,
        SUB8 = 5'b11100
    } shift_imm_op_e;

    // register data-processing operations, from bits 9:6
    typedef enum logic [3:0] {
        DP_AND, DP_EOR, DP_LSL, DP_LSR, DP_ASR, DP_ADC, DP_SBC, DP_ROR,
        DP_TST, DP_RSB, DP_CMP, DP_CMN, DP_ORR, DP_MUL, DP_BIC, DP_MVN
    } dp_op_e;

    // miscellaneous 16-bit group, from bits 11:5
    typedef enum logic [6:0] {
        ADD_SP_IMM  = 7'b0000000,
        SUB_SP_IMM  = 7'b0000100,
        MISC_SXTH   = 7'b0010000,
        MISC_SXTB   = 7'b0010010,
        MISC_UXTH   = 7'b0010100,
        MISC_UXTB   = 7'b0010110,
        MISC_PUSH   = 7'b0100000,
        MISC_REV    = 7'b1010000,
        MISC_REV16  = 7'b1010010,
        MISC_REVSH  = 7'b1010110,
        MISC_POP    = 7'b1100000,
        MISC_OTHER  = 7'b1111111
    } misc_op_e;

    typedef struct packed {
        logic [5:0] op;
        logic [9:0] low;
    } t16_view_t;

    // first half of BL carries S and the upper offset bits
    typedef struct packed {
        logic [4:0] marker;
        logic       s;
        logic [9:0] imm10;
    } bl_prefix_t;

    // second half of BL carries J1, J2 and the lower offset bits
    typedef struct packed {
        logic [1:0]  marker;
        logic        j1;
        logic        link;
        logic        j2;
        logic [10:0] imm11;
    } bl_suffix_t;

    typedef union packed {
        bl_prefix_t pre;
        bl_suffix_t suf;
    } bl_view_u;

    typedef union packed {
        t16_view_t t16;
        bl_view_u  bl;
    } thumb_halfword_u;

    function automatic opcode_e major_class(logic [5:0] op_bits);
        casez (op_bits)
            6'b00????: return SHIFT_IMM;
            6'b010000: return DATA_PROCESSING;
            6'b010001: return SPECIAL;
            6'b01001?: return LOAD_LITERAL;
            6'b0110??: return LOAD_STORE_IMM;
            6'b0111??: return LOAD_STORE_BYTE;
            6'b1000??: return LOAD_STORE_HW;
            6'b1001??: return LOAD_STORE_SP_R;
            6'b10100?: return GEN_PC_REL;
            6'b10101?: return GEN_SP_REL;
            6'b1011??: return MIS_16_BIT;
            6'b1101??: return COND_BRANCH;
            6'b11100?: return UNCOND_BRANCH;
            6'b11110?: return BL_PREFIX;
            6'b11101?,
            6'b11111?: return BL_SUFFIX;
            // register-offset load/store and LDM/STM are outside the decoded set
            default:   return SPECIAL;
        endcase
    endfunction

    // the grouped forms ignore their low two bits, ADD3/SUB3 need all five
    function automatic shift_imm_op_e shift_key(logic [4:0] bits);
        if (bits[4:2] == 3'b011) begin
            return shift_imm_op_e'(bits);
        end
        return shift_imm_op_e'({bits[4:2], 2'b00});
    endfunction

    function automatic misc_op_e misc_key(logic [6:0] bits);
        casez (bits)
            7'b00000??: return ADD_SP_IMM;
            7'b00001??: return SUB_SP_IMM;
            7'b001000?: return MISC_SXTH;
            7'b001001?: return MISC_SXTB;
            7'b001010?: return MISC_UXTH;
            7'b001011?: return MISC_UXTB;
            7'b010????: return MISC_PUSH;
            7'b101000?: return MISC_REV;
            7'b101001?: return MISC_REV16;
            7'b101011?: return MISC_REVSH;
            7'b110????: return MISC_POP;
            default:    return MISC_OTHER;
        endcase
    endfunction

endpackage

// File: source/thumb_pair_tracker.sv
`timescale 1ns/1ps
`include "thumb_decode_params.svh"

module thumb_pair_tracker (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       hw_valid_i,
    input  thumb_pkg::thumb_halfword_u hw_i,
    output logic                       second_half_o,
    output thumb_pkg::thumb_halfword_u prefix_hw_o,
    output logic                       complete_o,
    output logic                       pair_err_o
);
    import thumb_pkg::*;

    logic                   pending_q;
    logic [`THUMB_HALF-1:0] prefix_q;
    logic                   is_prefix;
    logic                   is_suffix;
    logic                   take_prefix;

    assign is_prefix = (major_class(hw_i.t16.op) == BL_PREFIX);
    assign is_suffix = (major_class(hw_i.t16.op) == BL_SUFFIX);

    // a prefix is only held when nothing is pending already
    assign take_prefix = hw_valid_i && !pending_q && is_prefix;

    assign second_half_o = pending_q;
    assign prefix_hw_o   = prefix_q;

    // with a prefix pending, whatever comes next ends an instruction,
    // either as the BL pair or as a plain 16-bit decode after a break
    assign complete_o = hw_valid_i && (pending_q || !is_prefix);
    assign pair_err_o = hw_valid_i && pending_q && !is_suffix;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (hw_valid_i) begin
            pending_q <= take_prefix;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_prefix) begin
            prefix_q <= hw_i;
        end
    end

    // a valid halfword either ends an instruction or leaves a prefix held
    prefix_consumed_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        hw_valid_i |=> (pending_q == !$past(complete_o))
    ) else $error("pending prefix state does not follow the last halfword");

endmodule

// File: source/thumb_imm_gen.sv
`timescale 1ns/1ps
`include "thumb_decode_params.svh"

module thumb_imm_gen (
    input  thumb_pkg::thumb_halfword_u hw_i,
    input  thumb_pkg::thumb_halfword_u prefix_hw_i,
    input  logic                       second_half_i,
    output logic [`THUMB_WORD-1:0]     imm_o,
    output logic                       has_imm_o
);
    import thumb_pkg::*;

    opcode_e       op_class;
    shift_imm_op_e shift_op;
    dp_op_e        dp_op;
    misc_op_e      misc_op;
    logic          bl_s;
    logic          bl_i1;
    logic          bl_i2;
    logic [24:0]   bl_offset;

    always_comb begin
        op_class = major_class(hw_i.t16.op);
        shift_op = shift_key(hw_i[13:9]);
        dp_op    = dp_op_e'(hw_i[9:6]);
        misc_op  = misc_key(hw_i[11:5]);

        // I1 and I2 are J1 and J2 folded with the sign from the prefix
        bl_s      = prefix_hw_i.bl.pre.s;
        bl_i1     = ~(hw_i.bl.suf.j1 ^ bl_s);
        bl_i2     = ~(hw_i.bl.suf.j2 ^ bl_s);
        bl_offset = {bl_s, bl_i1, bl_i2, prefix_hw_i.bl.pre.imm10,
                     hw_i.bl.suf.imm11, 1'b0};

        imm_o     = '0;
        has_imm_o = 1'b1;

        case (op_class)
            SHIFT_IMM: begin
                case (shift_op)
                    LSL, LSR, ASR: begin
                        imm_o = `THUMB_WORD'(hw_i[10:6]);
                    end
                    ADD3, SUB3: begin
                        imm_o = `THUMB_WORD'(hw_i[8:6]);
                    end
                    MOV8, CMP8, ADD8, SUB8: begin
                        imm_o = `THUMB_WORD'(hw_i[7:0]);
                    end
                    // register add and subtract carry no immediate
                    default: begin
                        has_imm_o = 1'b0;
                    end
                endcase
            end
            DATA_PROCESSING: begin
                // RSB is a subtract from an implicit zero
                if (dp_op != DP_RSB) begin
                    has_imm_o = 1'b0;
                end
            end
            LOAD_LITERAL: begin
                imm_o = `THUMB_WORD'({hw_i[7:0], 2'b00}) + `THUMB_WORD'(`PC_READ_OFFSET);
            end
            LOAD_STORE_IMM: begin
                imm_o = `THUMB_WORD'({hw_i[10:6], 2'b00});
            end
            LOAD_STORE_BYTE: begin
                imm_o = `THUMB_WORD'(hw_i[10:6]);
            end
            LOAD_STORE_HW: begin
                imm_o = `THUMB_WORD'({hw_i[10:6], 1'b0});
            end
            LOAD_STORE_SP_R, GEN_PC_REL, GEN_SP_REL: begin
                imm_o = `THUMB_WORD'({hw_i[7:0], 2'b00});
            end
            MIS_16_BIT: begin
                if (misc_op == ADD_SP_IMM || misc_op == SUB_SP_IMM) begin
                    imm_o = `THUMB_WORD'({hw_i[6:0], 2'b00});
                end else begin
                    has_imm_o = 1'b0;
                end
            end
            COND_BRANCH: begin
                // condition codes 1110 and 1111 are UDF and SVC, not branches
                if (hw_i[11:9] == 3'b111) begin
                    has_imm_o = 1'b0;
                end else begin
                    imm_o = `THUMB_WORD'($signed({hw_i[7:0], 1'b0}));
                end
            end
            UNCOND_BRANCH: begin
                imm_o = `THUMB_WORD'($signed({hw_i[10:0], 1'b0}));
            end
            BL_SUFFIX: begin
                // a suffix with no prefix in front of it is undefined
                if (second_half_i) begin
                    imm_o = `THUMB_WORD'($signed(bl_offset))
                          - `THUMB_WORD'(`BL_HALF_OFFSET);
                end else begin
                    has_imm_o = 1'b0;
                end
            end
            default: begin
                has_imm_o = 1'b0;
            end
        endcase
    end

    imm_known_a: assert final (!has_imm_o || !$isunknown(imm_o))
        else $error("immediate has unknown bits while marked valid");

endmodule

// File: source/thumb_field_decode.sv
`timescale 1ns/1ps
`include "thumb_decode_params.svh"

module thumb_field_decode (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       hw_valid_i,
    input  thumb_pkg::thumb_halfword_u hw_i,
    input  logic                       complete_i,
    input  logic                       pair_err_i,
    input  logic [`THUMB_WORD-1:0]     imm_i,
    input  logic                       has_imm_i,
    output logic                       dec_valid_o,
    output thumb_pkg::opcode_e         op_class_o,
    output logic [2:0]                 rd_o,
    output logic [2:0]                 rn_o,
    output logic [2:0]                 rm_o,
    output logic [`THUMB_WORD-1:0]     imm_o,
    output logic                       has_imm_o,
    output logic                       pair_error_o
);
    import thumb_pkg::*;

    opcode_e       op_class;
    shift_imm_op_e shift_op;
    misc_op_e      misc_op;
    logic [2:0]    rd;
    logic [2:0]    rn;
    logic [2:0]    rm;
    logic          load_en;

    assign load_en = hw_valid_i && complete_i;

    // both suffix patterns fold into BL_SUFFIX, a broken pair keeps its own class
    always_comb begin
        op_class = major_class(hw_i.t16.op);
        shift_op = shift_key(hw_i[13:9]);
        misc_op  = misc_key(hw_i[11:5]);
        rd = '0;
        rn = '0;
        rm = '0;

        case (op_class)
            SHIFT_IMM: begin
                case (shift_op)
                    LSL, LSR, ASR, ADD3, SUB3: begin
                        rd = hw_i[2:0];
                        rn = hw_i[5:3];
                    end
                    MOV8, CMP8, ADD8, SUB8: begin
                        rd = hw_i[10:8];
                    end
                    // three-register add and subtract
                    default: begin
                        rd = hw_i[2:0];
                        rn = hw_i[5:3];
                        rm = hw_i[8:6];
                    end
                endcase
            end
            DATA_PROCESSING, LOAD_STORE_IMM, LOAD_STORE_BYTE, LOAD_STORE_HW: begin
                rd = hw_i[2:0];
                rn = hw_i[5:3];
            end
            LOAD_LITERAL, LOAD_STORE_SP_R, GEN_PC_REL, GEN_SP_REL: begin
                rd = hw_i[10:8];
            end
            MIS_16_BIT: begin
                // only the extend and byte-reverse forms name low registers
                if (misc_op inside {MISC_SXTH, MISC_SXTB, MISC_UXTH, MISC_UXTB,
                                    MISC_REV, MISC_REV16, MISC_REVSH}) begin
                    rd = hw_i[2:0];
                    rn = hw_i[5:3];
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o  <= 1'b0;
            pair_error_o <= 1'b0;
            op_class_o   <= SHIFT_IMM;
            rd_o         <= '0;
            rn_o         <= '0;
            rm_o         <= '0;
            imm_o        <= '0;
            has_imm_o    <= 1'b0;
        end else begin
            dec_valid_o  <= load_en;
            pair_error_o <= load_en && pair_err_i;
            if (load_en) begin
                op_class_o <= op_class;
                rd_o       <= rd;
                rn_o       <= rn;
                rm_o       <= rm;
                imm_o      <= imm_i;
                has_imm_o  <= has_imm_i;
            end
        end
    end

    // a broken pair is always decoded, so its error pulse is never lost
    pair_error_decoded_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pair_err_i |-> complete_i
    ) else $error("pair error flagged on a halfword that completes no instruction");

endmodule

// File: source/thumb_decode_top.sv
`timescale 1ns/1ps
`include "thumb_decode_params.svh"

module thumb_decode_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       hw_valid_i,
    input  thumb_pkg::thumb_halfword_u hw_i,
    output logic                       dec_valid_o,
    output thumb_pkg::opcode_e         op_class_o,
    output logic [2:0]                 rd_o,
    output logic [2:0]                 rn_o,
    output logic [2:0]                 rm_o,
    output logic [`THUMB_WORD-1:0]     imm_o,
    output logic                       has_imm_o,
    output logic                       pair_error_o
);
    import thumb_pkg::*;

    logic                   second_half;
    thumb_halfword_u        prefix_hw;
    logic                   complete;
    logic                   pair_err;
    logic [`THUMB_WORD-1:0] imm;
    logic                   has_imm;

    thumb_pair_tracker u_pair (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .hw_valid_i    (hw_valid_i),
        .hw_i          (hw_i),
        .second_half_o (second_half),
        .prefix_hw_o   (prefix_hw),
        .complete_o    (complete),
        .pair_err_o    (pair_err)
    );

    // immediate is built combinationally and captured with the fields
    thumb_imm_gen u_imm (
        .hw_i          (hw_i),
        .prefix_hw_i   (prefix_hw),
        .second_half_i (second_half),
        .imm_o         (imm),
        .has_imm_o     (has_imm)
    );

    thumb_field_decode u_fields (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .hw_valid_i   (hw_valid_i),
        .hw_i         (hw_i),
        .complete_i   (complete),
        .pair_err_i   (pair_err),
        .imm_i        (imm),
        .has_imm_i    (has_imm),
        .dec_valid_o  (dec_valid_o),
        .op_class_o   (op_class_o),
        .rd_o         (rd_o),
        .rn_o         (rn_o),
        .rm_o         (rm_o),
        .imm_o        (imm_o),
        .has_imm_o    (has_imm_o),
        .pair_error_o (pair_error_o)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset is released on a rising edge after the hold time
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: testbench/tb_thumb_decode.sv
`timescale 1ns/1ps
`include "thumb_decode_params.svh"

module tb_thumb_decode;
    import thumb_pkg::*;

    localparam int DECODE_TIMEOUT = 20;
    localparam int RESET_TIMEOUT  = 40;

    logic                   clk;
    logic                   rst_n;
    logic                   hw_valid;
    thumb_halfword_u        hw;
    logic                   dec_valid;
    opcode_e                op_class;
    logic [2:0]             rd;
    logic [2:0]             rn;
    logic [2:0]             rm;
    logic [`THUMB_WORD-1:0] imm;
    logic                   has_imm;
    logic                   pair_error;

    int checks;
    int imm_errs;
    int class_errs;
    int flag_errs;
    int timing_errs;
    int timeouts;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    thumb_decode_top u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .hw_valid_i   (hw_valid),
        .hw_i         (hw),
        .dec_valid_o  (dec_valid),
        .op_class_o   (op_class),
        .rd_o         (rd),
        .rn_o         (rn),
        .rm_o         (rm),
        .imm_o        (imm),
        .has_imm_o    (has_imm),
        .pair_error_o (pair_error)
    );

    task automatic check_imm(input string what, input logic [`THUMB_WORD-1:0] exp_imm,
                             input logic exp_has);
        checks++;
        if (imm !== exp_imm || has_imm !== exp_has) begin
            imm_errs++;
            $display("ERR %0t %s: imm %h has_imm %b, expected %h has_imm %b",
                     $time, what, imm, has_imm, exp_imm, exp_has);
        end
    endtask

    task automatic check_class(input string what, input opcode_e exp_cls, input logic [2:0] exp_rd,
                               input logic [2:0] exp_rn, input logic [2:0] exp_rm);
        checks++;
        if (op_class !== exp_cls || rd !== exp_rd || rn !== exp_rn || rm !== exp_rm) begin
            class_errs++;
            $display("ERR %0t %s: class %s rd %0d rn %0d rm %0d, expected %s rd %0d rn %0d rm %0d",
                     $time, what, op_class.name(), rd, rn, rm, exp_cls.name(),
                     exp_rd, exp_rn, exp_rm);
        end
    endtask

    task automatic check_flag(input string what, input string flag, input logic got,
                              input logic exp);
        checks++;
        if (got !== exp) begin
            flag_errs++;
            $display("ERR %0t %s: %s is %b, expected %b", $time, what, flag, got, exp);
        end
    endtask

    task automatic drive_hw(input logic [15:0] bits);
        @(posedge clk);
        hw_valid <= 1'b1;
        hw       <= bits;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        hw_valid <= 1'b0;
    endtask

    task automatic send_alone(input logic [15:0] bits);
        drive_hw(bits);
        drive_idle();
    endtask

    // nothing may come out of the previous cycle's input
    task automatic check_quiet(input string what);
        @(negedge clk);
        check_flag(what, "dec_valid_o", dec_valid, 1'b0);
        check_flag(what, "pair_error_o", pair_error, 1'b0);
    endtask

    // the decode belongs to the halfword driven one edge before the last drive
    task automatic wait_decode(input string what, output logic got);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!dec_valid && waited < DECODE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        got = dec_valid;
        if (!dec_valid) begin
            timeouts++;
            $display("timeout: no decode arrived for %s within %0d cycles", what, waited);
        end else if (waited != 0) begin
            timing_errs++;
            $display("ERR %0t %s: decode arrived %0d cycles late", $time, what, waited);
        end
    endtask

    task automatic expect_decode(input string what, input opcode_e e_cls,
                                 input logic [2:0] e_rd, input logic [2:0] e_rn,
                                 input logic [2:0] e_rm, input logic [`THUMB_WORD-1:0] e_imm,
                                 input logic e_has, input logic e_err);
        logic got;
        wait_decode(what, got);
        if (got) begin
            check_class(what, e_cls, e_rd, e_rn, e_rm);
            check_imm(what, e_imm, e_has);
            check_flag(what, "pair_error_o", pair_error, e_err);
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("timeout: reset was never released");
        end
    endtask

    task automatic test_reset_idle();
        for (int i = 0; i < 6; i++) begin
            check_quiet("idle after reset");
        end
        check_class("outputs after reset", SHIFT_IMM, 3'd0, 3'd0, 3'd0);
        check_imm("outputs after reset", '0, 1'b0);
    endtask

    task automatic test_alu_forms();
        logic [1:0] op2;
        logic [4:0] imm5;
        logic [2:0] ra;
        logic [2:0] rb;
        logic [2:0] rc;
        logic [2:0] imm3;
        logic [7:0] imm8;
        logic       sub;
        for (int i = 0; i < 4; i++) begin
            op2  = 2'(i % 3);
            imm5 = 5'($urandom);
            ra   = 3'($urandom);
            rb   = 3'($urandom);
            rc   = 3'($urandom);
            imm3 = 3'($urandom);
            imm8 = 8'($urandom);
            sub  = 1'($urandom);
            send_alone({3'b000, op2, imm5, rb, ra});
            expect_decode("shift by immediate", SHIFT_IMM, ra, rb, 3'd0,
                          `THUMB_WORD'(imm5), 1'b1, 1'b0);
            send_alone({5'b00011, 1'b1, sub, imm3, rb, ra});
            expect_decode("add/sub 3-bit", SHIFT_IMM, ra, rb, 3'd0,
                          `THUMB_WORD'(imm3), 1'b1, 1'b0);
            // register add and subtract name all three fields and carry no immediate
            send_alone({5'b00011, 1'b0, sub, rc, rb, ra});
            expect_decode("add/sub register", SHIFT_IMM, ra, rb, rc, '0, 1'b0, 1'b0);
            send_alone({3'b001, 2'(i), ra, imm8});
            expect_decode("8-bit alu", SHIFT_IMM, ra, 3'd0, 3'd0,
                          `THUMB_WORD'(imm8), 1'b1, 1'b0);
            send_alone({6'b010000, 4'b1001, rb, ra});
            expect_decode("rsb", DATA_PROCESSING, ra, rb, 3'd0, '0, 1'b1, 1'b0);
        end
        // three strobes in a row, each decode lands one cycle after its own strobe
        drive_hw({5'b00000, imm5, rb, ra});
        drive_hw({5'b00100, rb, imm8});
        expect_decode("back-to-back lsl", SHIFT_IMM, ra, rb, 3'd0,
                      `THUMB_WORD'(imm5), 1'b1, 1'b0);
        drive_hw({7'b0001110, imm3, ra, rb});
        expect_decode("back-to-back mov", SHIFT_IMM, rb, 3'd0, 3'd0,
                      `THUMB_WORD'(imm8), 1'b1, 1'b0);
        drive_idle();
        expect_decode("back-to-back add3", SHIFT_IMM, rb, ra, 3'd0,
                      `THUMB_WORD'(imm3), 1'b1, 1'b0);
    endtask

    task automatic test_mem_forms();
        logic       l;
        logic [2:0] rt;
        logic [2:0] rb;
        logic [4:0] imm5;
        logic [7:0] imm8;
        logic [6:0] imm7;
        for (int i = 0; i < 4; i++) begin
            l    = 1'($urandom);
            rt   = 3'($urandom);
            rb   = 3'($urandom);
            imm5 = 5'($urandom);
            imm8 = 8'($urandom);
            imm7 = 7'($urandom);
            send_alone({4'b0110, l, imm5, rb, rt});
            expect_decode("word load/store", LOAD_STORE_IMM, rt, rb, 3'd0,
                          `THUMB_WORD'(imm5) << 2, 1'b1, 1'b0);
            send_alone({4'b0111, l, imm5, rb, rt});
            expect_decode("byte load/store", LOAD_STORE_BYTE, rt, rb, 3'd0,
                          `THUMB_WORD'(imm5), 1'b1, 1'b0);
            send_alone({4'b1000, l, imm5, rb, rt});
            expect_decode("halfword load/store", LOAD_STORE_HW, rt, rb, 3'd0,
                          `THUMB_WORD'(imm5) << 1, 1'b1, 1'b0);
            // the PC reads four bytes ahead of a literal load
            send_alone({5'b01001, rt, imm8});
            expect_decode("literal load", LOAD_LITERAL, rt, 3'd0, 3'd0,
                          (`THUMB_WORD'(imm8) << 2) + `PC_READ_OFFSET, 1'b1, 1'b0);
            send_alone({4'b1001, l, rt, imm8});
            expect_decode("sp-relative load/store", LOAD_STORE_SP_R, rt, 3'd0, 3'd0,
                          `THUMB_WORD'(imm8) << 2, 1'b1, 1'b0);
            send_alone({5'b10100, rt, imm8});
            expect_decode("adr", GEN_PC_REL, rt, 3'd0, 3'd0,
                          `THUMB_WORD'(imm8) << 2, 1'b1, 1'b0);
            send_alone({5'b10101, rt, imm8});
            expect_decode("add from sp", GEN_SP_REL, rt, 3'd0, 3'd0,
                          `THUMB_WORD'(imm8) << 2, 1'b1, 1'b0);
            send_alone({8'b10110000, l, imm7});
            expect_decode("sp adjust", MIS_16_BIT, 3'd0, 3'd0, 3'd0,
                          `THUMB_WORD'(imm7) << 2, 1'b1, 1'b0);
        end
    endtask

    task automatic test_branches();
        logic [3:0]  cond;
        logic [7:0]  imm8;
        logic [10:0] imm11;
        int          offset;
        for (int i = 0; i < 6; i++) begin
            cond  = 4'($urandom % 14);
            // alternate the sign bit so both directions are covered
            imm8  = {1'(i), 7'($urandom)};
            imm11 = {1'(i), 10'($urandom)};
            send_alone({4'b1101, cond, imm8});
            offset = int'($signed(imm8)) * 2;
            expect_decode("conditional branch", COND_BRANCH, 3'd0, 3'd0, 3'd0,
                          `THUMB_WORD'(offset), 1'b1, 1'b0);
            send_alone({5'b11100, imm11});
            offset = int'($signed(imm11)) * 2;
            expect_decode("unconditional branch", UNCOND_BRANCH, 3'd0, 3'd0, 3'd0,
                          `THUMB_WORD'(offset), 1'b1, 1'b0);
        end
    endtask

    task automatic test_bl_pairs();
        logic        s;
        logic        link;
        logic        j1;
        logic        j2;
        logic [9:0]  imm10;
        logic [10:0] imm11;
        int          offset;
        for (int gap = 0; gap < 8; gap++) begin
            s     = 1'($urandom);
            link  = 1'($urandom);
            imm10 = 10'($urandom);
            imm11 = 11'($urandom);
            // suffix patterns 11111 and 11101 both have J1 and J2 set
            j1 = 1'b1;
            j2 = 1'b1;
            drive_hw({5'b11110, s, imm10});
            for (int k = 0; k < gap % 4; k++) begin
                drive_idle();
                check_quiet("bl prefix waiting");
            end
            drive_hw({2'b11, j1, link, j2, imm11});
            check_quiet("bl prefix alone");
            drive_idle();
            // bit 24 of the offset carries S with negative weight, bits 23 and 22
            // are set where J1 and J2 equal S
            offset = int'(imm11) * 2 + int'(imm10) * 4096 - `BL_HALF_OFFSET;
            if (j1 == s) begin
                offset += 32'h0080_0000;
            end
            if (j2 == s) begin
                offset += 32'h0040_0000;
            end
            if (s) begin
                offset -= 32'h0100_0000;
            end
            expect_decode("bl pair", BL_SUFFIX, 3'd0, 3'd0, 3'd0,
                          `THUMB_WORD'(offset), 1'b1, 1'b0);
            drive_idle();
            check_quiet("after bl pair");
        end
    endtask

    task automatic test_broken_and_undefined();
        logic [2:0] ra;
        logic [2:0] rb;
        logic [7:0] imm8;
        for (int i = 0; i < 3; i++) begin
            ra   = 3'($urandom);
            rb   = 3'($urandom);
            imm8 = 8'($urandom);
            drive_hw({5'b11110, 11'($urandom)});
            if (i > 0) begin
                drive_idle();
                check_quiet("prefix before break");
            end
            drive_hw({5'b00100, ra, imm8});
            check_quiet("prefix before break");
            drive_idle();
            expect_decode("broken pair", SHIFT_IMM, ra, 3'd0, 3'd0,
                          `THUMB_WORD'(imm8), 1'b1, 1'b1);
            // the prefix was dropped, so a lone suffix is undefined
            send_alone({5'b11111, 11'($urandom)});
            expect_decode("lone suffix", BL_SUFFIX, 3'd0, 3'd0, 3'd0, '0, 1'b0, 1'b0);
            send_alone({8'b11011110, imm8});
            expect_decode("udf", COND_BRANCH, 3'd0, 3'd0, 3'd0, '0, 1'b0, 1'b0);
            send_alone({8'b11011111, imm8});
            expect_decode("svc", COND_BRANCH, 3'd0, 3'd0, 3'd0, '0, 1'b0, 1'b0);
            send_alone({10'b0100000000, rb, ra});
            expect_decode("register and", DATA_PROCESSING, ra, rb, 3'd0, '0, 1'b0, 1'b0);
        end
    endtask

    initial begin
        int unsigned seed;
        int          total;
        hw_valid    = 1'b0;
        hw          = '0;
        checks      = 0;
        imm_errs    = 0;
        class_errs  = 0;
        flag_errs   = 0;
        timing_errs = 0;
        timeouts    = 0;
        seed        = 32'h812e;
        void'($urandom(seed));

        wait_reset();
        test_reset_idle();
        test_alu_forms();
        test_mem_forms();
        test_branches();
        test_bl_pairs();
        test_broken_and_undefined();
        drive_idle();

        total = imm_errs + class_errs + flag_errs + timing_errs + timeouts;
        $display("checks %0d, imm mismatches %0d, class mismatches %0d, flag mismatches %0d, %s",
                 checks, imm_errs, class_errs, flag_errs,
                 $sformatf("late decodes %0d, timeouts %0d", timing_errs, timeouts));
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: thumb_decode.f
+incdir+source
source/thumb_pkg.sv
source/thumb_pair_tracker.sv
source/thumb_imm_gen.sv
source/thumb_field_decode.sv
source/thumb_decode_top.sv
testbench/tb_clock_gen.sv
testbench/tb_thumb_decode.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_thumb_decode
FILELIST  := thumb_decode.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
